// File: files.f
logic/pms_pkg.sv
logic/pms_ctrl.sv
logic/mem_lane.sv
logic/except_sel.sv
logic/premem_stage.sv
dv/tb_premem.sv

// File: Makefile
TOP := tb_premem

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f

# pass only when the pass line shows up in the simulator output
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -x '>>> PASS'

clean:
	rm -rf obj_dir

// File: dv/tb_premem.sv
`timescale 1ns/1ps

module tb_premem import pms_pkg::*; ();

    localparam int TIMEOUT = 40;

    // one-hot kinds with byte as the msb
    localparam ls_type_t LS_B  = 7'b100_0000;
    localparam ls_type_t LS_H  = 7'b001_0000;
    localparam ls_type_t LS_W  = 7'b000_0100;
    localparam ls_type_t LS_WL = 7'b000_0010;
    localparam ls_type_t LS_WR = 7'b000_0001;

    logic            clk = 1'b0;
    logic            reset;
    logic            es_valid;
    es_bus_t         es_bus;
    logic            ms_allowin;
    logic            addr_ok1;
    logic            addr_ok2;
    logic [XLEN-1:0] epc;
    logic            allowin;
    logic            ms_valid;
    ms_lane_t [1:0]  ms_bus;
    cache_req_t      cache_req1;
    cache_req_t      cache_req2;
    logic            clear_all;
    logic [XLEN-1:0] reflush_pc;
    except_rpt_t     except_rpt;

    ms_lane_t [1:0]  ms_snap;  // ms_bus seen in the addr_ok cycle
    logic [31:0]     rng = 32'h00de87fb;
    string           test_name;

    always #10 clk = ~clk;

    premem_stage u_premem_stage (
        .clk        (clk),
        .reset      (reset),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .ms_allowin (ms_allowin),
        .addr_ok1   (addr_ok1),
        .addr_ok2   (addr_ok2),
        .epc        (epc),
        .allowin    (allowin),
        .ms_valid   (ms_valid),
        .ms_bus     (ms_bus),
        .cache_req1 (cache_req1),
        .cache_req2 (cache_req2),
        .clear_all  (clear_all),
        .reflush_pc (reflush_pc),
        .except_rpt (except_rpt)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic expect_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    // store tables for strobe, size and lane-shifted data
    function automatic void store_ref(input ls_type_t ls, input logic [1:0] off,
                                      input logic [31:0] rt, output logic [3:0] strb,
                                      output logic [1:0] size, output logic [31:0] data);
        if (ls.b) begin
            strb = 4'b0001 << off;
            size = 2'd0;
            data = {4{rt[7:0]}};
        end else if (ls.h) begin
            strb = 4'b0011 << off;
            size = 2'd1;
            data = {2{rt[15:0]}};
        end else if (ls.w) begin
            strb = 4'b1111;
            size = 2'd2;
            data = rt;
        end else if (ls.wl) begin
            strb = 4'b1111 >> (3 - off);  // bytes up to the addressed one
            data = rt >> (8 * (3 - off));
            size = (off == 2'd0) ? 2'd0 : (off == 2'd1) ? 2'd1 : 2'd2;
        end else begin
            strb = 4'b1111 << off;
            data = rt << (8 * off);
            size = (off == 2'd3) ? 2'd0 : (off == 2'd2) ? 2'd1 : 2'd2;
        end
    endfunction

    function automatic lane_in_t access_lane(input logic [31:0] pc, input logic [31:0] addr,
                                             input logic [31:0] rt, input logic [31:0] res,
                                             input ls_type_t ls, input logic store);
        lane_in_t l;
        l          = '0;
        l.valid    = 1'b1;
        l.pc       = pc;
        l.mem_addr = addr;
        l.rt_value = rt;
        l.result   = res;
        l.ls_type  = ls;
        l.load_op  = ~store;
        l.mem_we   = store;
        l.gr_we    = ~store;
        l.dest     = 5'd8;
        return l;
    endfunction

    function automatic lane_in_t alu_lane(input logic [31:0] pc, input logic [31:0] res);
        lane_in_t l;
        l        = '0;
        l.valid  = 1'b1;
        l.pc     = pc;
        l.result = res;
        l.gr_we  = 1'b1;
        l.dest   = 5'd2;
        return l;
    endfunction

    function automatic es_bus_t pair_up(input lane_in_t a, input lane_in_t b,
                                        input logic [31:0] br);
        es_bus_t bus;
        bus.lane1     = a;
        bus.lane2     = b;
        bus.br_target = br;
        return bus;
    endfunction

    function automatic logic request_seen(input int lane);
        return (lane == 1) ? cache_req1.valid : cache_req2.valid;
    endfunction

    // returns just after the edge that registered the bundle
    task automatic send(input es_bus_t bus);
        int n;
        n = 0;
        @(posedge clk);
        es_valid <= 1'b1;
        es_bus   <= bus;
        @(negedge clk);
        while (!allowin && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (allowin) else begin
            $display("timeout: stage never accepted the bundle in %s", test_name);
            abort_run();
        end
        @(posedge clk);
        es_valid <= 1'b0;
    endtask

    // one addr_ok pulse once the lane requests
    task automatic grant_addr(input int lane, input logic exp_ms_valid);
        int n;
        n = 0;
        @(negedge clk);
        while (!request_seen(lane) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        assert (request_seen(lane)) else begin
            $display("timeout: lane %0d never raised a cache request in %s", lane, test_name);
            abort_run();
        end
        @(posedge clk);
        if (lane == 1) begin
            addr_ok1 <= 1'b1;
        end else begin
            addr_ok2 <= 1'b1;
        end
        @(negedge clk);
        expect_bit("ms_valid on addr_ok", exp_ms_valid, ms_valid);
        ms_snap = ms_bus;
        @(posedge clk);
        addr_ok1 <= 1'b0;
        addr_ok2 <= 1'b0;
    endtask

    task automatic reset_idle();
        test_name = "reset_idle";
        @(negedge clk);
        expect_bit("ms_valid", 1'b0, ms_valid);
        expect_bit("req1 valid", 1'b0, cache_req1.valid);
        expect_bit("req2 valid", 1'b0, cache_req2.valid);
        expect_bit("clear_all", 1'b0, clear_all);
        expect_bit("allowin", 1'b1, allowin);
    endtask

    task automatic store_encoding();
        ls_type_t    kinds [5];
        ls_type_t    ls;
        logic [1:0]  off;
        logic [2:0]  seg;
        logic [31:0] rt;
        logic [31:0] addr;
        logic [31:0] phys;
        logic [3:0]  e_strb;
        logic [1:0]  e_size;
        logic [31:0] e_data;
        logic        kseg1;
        int          k;
        int          o;
        test_name = "store_encoding";
        kinds = '{LS_B, LS_H, LS_W, LS_WL, LS_WR};
        kseg1 = 1'b0;
        for (k = 0; k < 5; k++) begin
            for (o = 0; o < 4; o++) begin
                ls  = kinds[k];
                off = 2'(o);
                if ((ls.h && off[0]) || (ls.w && off != 2'd0)) begin
                    continue;
                end
                kseg1 = ~kseg1;
                seg   = kseg1 ? 3'b101 : 3'b100;
                rt    = next_rand();
                addr  = next_rand();
                addr  = {seg, addr[28:2], off};
                phys  = {3'b000, addr[28:2], ls.wl ? 2'b00 : off};
                store_ref(ls, off, rt, e_strb, e_size, e_data);
                send(pair_up(access_lane(32'h8000_0040, addr, rt, 32'h0, ls, 1'b1), '0, 32'h0));
                @(negedge clk);
                expect_bit("valid", 1'b1, cache_req1.valid);
                expect_bit("op", 1'b1, cache_req1.op);
                expect_bit("uncache", kseg1, cache_req1.uncache);
                check_word("tag", 32'(phys[31:12]), 32'(cache_req1.tag));
                check_word("index", 32'(phys[11:4]), 32'(cache_req1.index));
                check_word("offset", 32'(phys[3:0]), 32'(cache_req1.offset));
                check_word("size", 32'(e_size), 32'(cache_req1.size));
                check_word("wstrb", 32'(e_strb), 32'(cache_req1.wstrb));
                check_word("wdata", e_data, cache_req1.wdata);
                grant_addr(1, 1'b1);
            end
        end
    endtask

    task automatic back_pressure();
        lane_in_t   ld;
        cache_req_t held;
        int         i;
        test_name = "back_pressure";
        ld = access_lane(32'h8000_1000, 32'h8001_2344, 32'h0, 32'h0, LS_W, 1'b0);
        send(pair_up(ld, '0, 32'h8000_2000));
        @(negedge clk);
        held = cache_req1;
        expect_bit("req valid", 1'b1, held.valid);
        for (i = 0; i < 5; i++) begin
            @(negedge clk);
            expect_bit("req held", 1'b1, cache_req1 == held);
            expect_bit("ms_valid before addr_ok", 1'b0, ms_valid);
        end
        grant_addr(1, 1'b1);
        @(negedge clk);
        expect_bit("req after addr_ok", 1'b0, cache_req1.valid);
        // memory stalled before the bundle arrives
        @(posedge clk);
        ms_allowin <= 1'b0;
        send(pair_up(ld, '0, 32'h8000_2000));
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            expect_bit("req under stall", 1'b0, cache_req1.valid);
            expect_bit("allowin under stall", 1'b0, allowin);
            expect_bit("ms_valid under stall", 1'b0, ms_valid);
        end
        @(posedge clk);
        ms_allowin <= 1'b1;
        grant_addr(1, 1'b1);
    endtask

    task automatic alignment_faults();
        lane_in_t l1;
        lane_in_t l2;
        test_name = "alignment_faults";
        l1 = access_lane(32'h8000_0100, 32'h8000_4002, 32'h0, 32'h0, LS_W, 1'b0);
        l2 = access_lane(32'h8000_0104, 32'h8000_4010, 32'h0, 32'h0, LS_W, 1'b0);
        send(pair_up(l1, l2, 32'h8000_0500));
        @(negedge clk);
        expect_bit("ex", 1'b1, except_rpt.ex);
        check_word("ex_type", 32'(EXC_ADEL), 32'(except_rpt.ex_type));
        check_word("badvaddr", 32'h8000_4002, except_rpt.badvaddr);
        check_word("pc", 32'h8000_0100, except_rpt.pc);
        expect_bit("clear_all", 1'b1, clear_all);
        check_word("reflush_pc", EXC_VEC, reflush_pc);
        expect_bit("req1 valid", 1'b0, cache_req1.valid);
        expect_bit("req2 valid", 1'b0, cache_req2.valid);
        expect_bit("ms_valid", 1'b0, ms_valid);
        @(negedge clk);
        expect_bit("clear_all after flush", 1'b0, clear_all);
        expect_bit("allowin after flush", 1'b1, allowin);
        // misaligned lane 2 store while lane 1 goes on
        l1 = alu_lane(32'h8000_0200, 32'h1234_5678);
        l2 = access_lane(32'h8000_0204, 32'h8000_6001, next_rand(), 32'h0, LS_H, 1'b1);
        send(pair_up(l1, l2, 32'h8000_0500));
        @(negedge clk);
        expect_bit("ex lane2", 1'b1, except_rpt.ex);
        check_word("ex_type lane2", 32'(EXC_ADES), 32'(except_rpt.ex_type));
        check_word("pc lane2", 32'h8000_0204, except_rpt.pc);
        check_word("badvaddr lane2", 32'h8000_6001, except_rpt.badvaddr);
        expect_bit("clear_all lane2", 1'b1, clear_all);
        expect_bit("req2 valid lane2", 1'b0, cache_req2.valid);
        expect_bit("ms_valid lane1 done", 1'b1, ms_valid);
        expect_bit("ms lane1 valid", 1'b1, ms_bus[0].valid);
        check_word("ms lane1 result", 32'h1234_5678, ms_bus[0].result);
        expect_bit("ms lane2 valid", 1'b0, ms_bus[1].valid);
    endtask

    task automatic flush_targets();
        lane_in_t l1;
        lane_in_t l2;
        test_name = "flush_targets";
        @(posedge clk);
        epc <= 32'h8000_3330;
        l1      = alu_lane(32'h8000_0300, 32'h0);
        l1.eret = 1'b1;
        l2 = access_lane(32'h8000_0304, 32'h8000_7000, 32'h0, 32'h0, LS_W, 1'b0);
        send(pair_up(l1, l2, 32'h8000_0900));
        @(negedge clk);
        check_word("reflush_pc eret", 32'h8000_3330, reflush_pc);
        expect_bit("clear_all eret", 1'b1, clear_all);
        expect_bit("rpt eret", 1'b1, except_rpt.eret);
        expect_bit("rpt ex eret", 1'b0, except_rpt.ex);
        expect_bit("req2 valid eret", 1'b0, cache_req2.valid);
        expect_bit("ms_valid eret", 1'b0, ms_valid);
        // tlb refill on a load
        l1 = access_lane(32'h8000_0400, 32'h0040_0000, 32'h0, 32'h0, LS_W, 1'b0);
        l1.es_except   = 1'b1;
        l1.es_exccode  = 5'd2;
        l1.es_badvaddr = 32'h0040_0000;
        l1.refill      = 1'b1;
        send(pair_up(l1, '0, 32'h8000_0900));
        @(negedge clk);
        check_word("reflush_pc refill", REFILL_VEC, reflush_pc);
        check_word("ex_type refill", 32'd2, 32'(except_rpt.ex_type));
        check_word("badvaddr refill", 32'h0040_0000, except_rpt.badvaddr);
        expect_bit("req1 valid refill", 1'b0, cache_req1.valid);
        // execute code wins over a misaligned address
        l1 = access_lane(32'h8000_0500, 32'h8000_5003, 32'h0, 32'h0, LS_H, 1'b0);
        l1.es_except   = 1'b1;
        l1.es_exccode  = 5'd10;
        l1.es_badvaddr = 32'h8000_0600;
        send(pair_up(l1, alu_lane(32'h8000_0504, 32'h1), 32'h8000_0900));
        @(negedge clk);
        check_word("reflush_pc es", EXC_VEC, reflush_pc);
        check_word("ex_type es", 32'd10, 32'(except_rpt.ex_type));
        check_word("badvaddr es", 32'h8000_0600, except_rpt.badvaddr);
        check_word("pc es", 32'h8000_0500, except_rpt.pc);
    endtask

    task automatic dual_loads();
        logic [31:0] r1;
        logic [31:0] r2;
        lane_in_t    l1;
        lane_in_t    l2;
        int          i;
        test_name = "dual_loads";
        r1 = next_rand();
        r2 = next_rand();
        l1 = access_lane(32'h8000_0700, 32'h8000_7100, 32'h0, r1, LS_W, 1'b0);
        l2 = access_lane(32'h8000_0704, 32'h8000_7202, 32'h0, r2, LS_H, 1'b0);
        send(pair_up(l1, l2, 32'h8000_0800));
        @(negedge clk);
        expect_bit("req1 valid", 1'b1, cache_req1.valid);
        expect_bit("req2 valid", 1'b1, cache_req2.valid);
        expect_bit("clear_all", 1'b0, clear_all);
        check_word("reflush_pc", 32'h8000_0800, reflush_pc);
        grant_addr(2, 1'b0);
        @(negedge clk);
        expect_bit("req2 dropped after addr_ok", 1'b0, cache_req2.valid);
        expect_bit("req1 still waiting", 1'b1, cache_req1.valid);
        @(posedge clk);
        ms_allowin <= 1'b0;
        for (i = 0; i < 2; i++) begin
            @(negedge clk);
            expect_bit("req1 under stall", 1'b0, cache_req1.valid);
            expect_bit("req2 latched", 1'b0, cache_req2.valid);
            expect_bit("ms_valid under stall", 1'b0, ms_valid);
            expect_bit("allowin under stall", 1'b0, allowin);
        end
        @(posedge clk);
        ms_allowin <= 1'b1;
        grant_addr(1, 1'b1);
        check_word("lane1 result", r1, ms_snap[0].result);
        check_word("lane1 offset", 32'd0, 32'(ms_snap[0].offset));
        expect_bit("lane2 valid", 1'b1, ms_snap[1].valid);
        check_word("lane2 offset", 32'd2, 32'(ms_snap[1].offset));
        check_word("lane2 result", r2, ms_snap[1].result);
        check_word("lane2 pc", 32'h8000_0704, ms_snap[1].pc);
    endtask

    initial begin
        reset      = 1'b1;
        es_valid   = 1'b0;
        es_bus     = '0;
        ms_allowin = 1'b1;
        addr_ok1   = 1'b0;
        addr_ok2   = 1'b0;
        epc        = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        reset_idle();
        store_encoding();
        back_pressure();
        alignment_faults();
        flush_targets();
        dual_loads();
        $display(">>> PASS");
        $finish;
    end

endmodule

// File: logic/premem_stage.sv
`timescale 1ns/1ps

module premem_stage import pms_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  es_valid,
    input  es_bus_t               es_bus,
    input  logic                  ms_allowin,
    input  logic                  addr_ok1,
    input  logic                  addr_ok2,
    input  logic [XLEN-1:0]       epc,
    output logic                  allowin,
    output logic                  ms_valid,
    output ms_lane_t [1:0]        ms_bus,
    output cache_req_t            cache_req1,
    output cache_req_t            cache_req2,
    output logic                  clear_all,
    output logic [XLEN-1:0]       reflush_pc,
    output except_rpt_t           except_rpt
);

    es_bus_t      bus_q;
    lane_status_t st1;
    lane_status_t st2;
    logic         req_en1;
    logic         req_en2;
    logic         lane2_live;

    pms_ctrl u_pms_ctrl (
        .clk        (clk),
        .reset      (reset),
        .es_valid   (es_valid),
        .es_bus     (es_bus),
        .ms_allowin (ms_allowin),
        .st1        (st1),
        .st2        (st2),
        .addr_ok1   (addr_ok1),
        .addr_ok2   (addr_ok2),
        .allowin    (allowin),
        .bus_q      (bus_q),
        .req_en1    (req_en1),
        .req_en2    (req_en2),
        .ms_valid   (ms_valid),
        .lane2_live (lane2_live),
        .clear_all  (clear_all)
    );

    mem_lane u_lane1 (
        .lane    (bus_q.lane1),
        .req_en  (req_en1),
        .addr_ok (addr_ok1),
        .req     (cache_req1),
        .status  (st1)
    );

    mem_lane u_lane2 (
        .lane    (bus_q.lane2),
        .req_en  (req_en2),
        .addr_ok (addr_ok2),
        .req     (cache_req2),
        .status  (st2)
    );

    except_sel u_except_sel (
        .st1        (st1),
        .st2        (st2),
        .lane2_live (lane2_live),
        .epc        (epc),
        .br_target  (bus_q.br_target),
        .reflush_pc (reflush_pc),
        .rpt        (except_rpt)
    );

    // index 0 is the older lane
    assign ms_bus[0] = '{
        valid: bus_q.lane1.valid, ls_type: bus_q.lane1.ls_type,
        offset: bus_q.lane1.mem_addr[1:0], load_op: bus_q.lane1.load_op,
        mem_we: bus_q.lane1.mem_we, gr_we: bus_q.lane1.gr_we, dest: bus_q.lane1.dest,
        rt_value: bus_q.lane1.rt_value, result: bus_q.lane1.result, pc: bus_q.lane1.pc
    };
    assign ms_bus[1] = '{
        valid: lane2_live, ls_type: bus_q.lane2.ls_type,
        offset: bus_q.lane2.mem_addr[1:0], load_op: bus_q.lane2.load_op,
        mem_we: bus_q.lane2.mem_we, gr_we: bus_q.lane2.gr_we, dest: bus_q.lane2.dest,
        rt_value: bus_q.lane2.rt_value, result: bus_q.lane2.result, pc: bus_q.lane2.pc
    };

endmodule

// File: logic/except_sel.sv
`timescale 1ns/1ps

module except_sel import pms_pkg::*; (
    input  lane_status_t    st1,
    input  lane_status_t    st2,
    input  logic            lane2_live,
    input  logic [XLEN-1:0] epc,
    input  logic [XLEN-1:0] br_target,
    output logic [XLEN-1:0] reflush_pc,
    output except_rpt_t     rpt
);

    logic fl1;
    logic ex2;
    logic eret2;
    logic fl2;

    function automatic logic [XLEN-1:0] flush_target(input lane_status_t st,
                                                     input logic [XLEN-1:0] epc_v,
                                                     input logic [XLEN-1:0] br_v);
        if (st.refill) begin
            return REFILL_VEC;
        end else if (st.except) begin
            return EXC_VEC;
        end else if (st.eret) begin
            return epc_v;
        end
        return br_v;
    endfunction

    assign fl1   = st1.except | st1.eret;
    assign ex2   = st2.except & ~fl1;  // older lane first
    assign eret2 = st2.eret & lane2_live;
    assign fl2   = ex2 | eret2;

    assign reflush_pc = fl1 ? flush_target(st1, epc, br_target) :
                        fl2 ? flush_target(st2, epc, br_target) : br_target;

    assign rpt.ex       = st1.except | ex2;
    assign rpt.ex_type  = st1.except ? st1.exccode  : ex2 ? st2.exccode  : 5'd0;
    assign rpt.bd       = st1.except ? st1.bd       : ex2 & st2.bd;
    assign rpt.pc       = st1.except ? st1.pc       : ex2 ? st2.pc       : '0;
    assign rpt.badvaddr = st1.except ? st1.badvaddr : ex2 ? st2.badvaddr : '0;
    assign rpt.eret     = st1.eret | eret2;

endmodule

// File: logic/mem_lane.sv
`timescale 1ns/1ps

module mem_lane import pms_pkg::*; (
    input  lane_in_t     lane,
    input  logic         req_en,
    input  logic         addr_ok,
    output cache_req_t   req,
    output lane_status_t status
);

    ls_type_t        ls;
    logic [1:0]      off;
    logic [XLEN-1:0] rt;
    logic [XLEN-1:0] va;
    cache_addr_u     pa;
    logic            need_mem;
    logic            misalign;
    logic            adel;
    logic            ades;
    logic            except;
    logic [4:0]      exccode;
    logic            req_v;
    logic [1:0]      size;
    logic [3:0]      strb;
    logic [XLEN-1:0] wdata;

    assign ls  = lane.ls_type;
    assign off = lane.mem_addr[1:0];
    assign rt  = lane.rt_value;

    assign need_mem = lane.valid & (lane.load_op | lane.mem_we);

    assign misalign = ((ls.h | ls.hu) & off[0]) | (ls.w & (off != 2'b00));
    assign adel     = lane.valid & lane.load_op & misalign;
    assign ades     = lane.valid & lane.mem_we & misalign;
    assign except   = (lane.valid & lane.es_except) | adel | ades;

    // code from execute wins
    assign exccode = lane.es_except ? lane.es_exccode :
                     adel           ? EXC_ADEL :
                     ades           ? EXC_ADES : 5'd0;

    assign va     = ls.wl ? {lane.mem_addr[XLEN-1:2], 2'b00} : lane.mem_addr;
    assign pa.raw = {3'b000, va[28:0]};  // kseg0/kseg1 direct map

    always_comb begin
        size  = 2'd0;
        strb  = 4'b0000;
        wdata = '0;
        if (ls.b || ls.bu) begin
            strb  = 4'b0001 << off;
            wdata = {4{rt[7:0]}};
        end else if (ls.h || ls.hu) begin
            size  = 2'd1;
            strb  = off[1] ? 4'b1100 : 4'b0011;
            wdata = {2{rt[15:0]}};
        end else if (ls.w) begin
            size  = 2'd2;
            strb  = 4'b1111;
            wdata = rt;
        end else if (ls.wl) begin
            case (off)
                2'd0: begin
                    strb  = 4'b0001;
                    wdata = {24'b0, rt[31:24]};
                end
                2'd1: begin
                    size  = 2'd1;
                    strb  = 4'b0011;
                    wdata = {16'b0, rt[31:16]};
                end
                2'd2: begin
                    size  = 2'd2;
                    strb  = 4'b0111;
                    wdata = {8'b0, rt[31:8]};
                end
                default: begin
                    size  = 2'd2;
                    strb  = 4'b1111;
                    wdata = rt;
                end
            endcase
        end else if (ls.wr) begin
            case (off)
                2'd0: begin
                    size  = 2'd2;
                    strb  = 4'b1111;
                    wdata = rt;
                end
                2'd1: begin
                    size  = 2'd2;
                    strb  = 4'b1110;
                    wdata = {rt[23:0], 8'b0};
                end
                2'd2: begin
                    size  = 2'd1;
                    strb  = 4'b1100;
                    wdata = {rt[15:0], 16'b0};
                end
                default: begin
                    strb  = 4'b1000;
                    wdata = {rt[7:0], 24'b0};
                end
            endcase
        end
    end

    assign req_v = req_en & need_mem & ~except;

    assign req = '{
        valid:   req_v,
        op:      req_v & lane.mem_we,
        uncache: (va[31:29] == 3'b101),  // kseg1
        tag:     pa.split.tag,
        index:   pa.split.index,
        offset:  pa.split.offset,
        size:    size,
        wstrb:   (req_v & lane.mem_we) ? strb : 4'b0000,
        wdata:   wdata
    };

    assign status = '{
        need_mem: need_mem,
        except:   except,
        exccode:  exccode,
        badvaddr: lane.es_except ? lane.es_badvaddr : va,
        eret:     lane.valid & lane.eret,
        refill:   lane.valid & lane.refill,
        bd:       lane.bd,
        pc:       lane.pc
    };

    always_comb begin
        assert final (!(req.valid && status.except));
        assert final (!addr_ok || req.valid);  // cache only acks a live request
    end

endmodule

// File: logic/pms_ctrl.sv
`timescale 1ns/1ps

module pms_ctrl import pms_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         es_valid,
    input  es_bus_t      es_bus,
    input  logic         ms_allowin,
    input  lane_status_t st1,
    input  lane_status_t st2,
    input  logic         addr_ok1,
    input  logic         addr_ok2,
    output logic         allowin,
    output es_bus_t      bus_q,
    output logic         req_en1,
    output logic         req_en2,
    output logic         ms_valid,
    output logic         lane2_live,
    output logic         clear_all
);

    logic    valid_q;
    es_bus_t bus_r;
    logic    acc1;  // addr_ok seen for lane 1
    logic    acc2;
    logic    ready1;
    logic    ready2;
    logic    ready_go;
    logic    flush1;

    // lane valids follow the stage valid and lane 1 is always present
    always_comb begin
        bus_q             = bus_r;
        bus_q.lane1.valid = valid_q;
        bus_q.lane2.valid = valid_q & bus_r.lane2.valid;
    end

    assign flush1    = st1.except | st1.eret;
    assign clear_all = flush1 | st2.except | st2.eret;

    assign ready1   = ~st1.need_mem | addr_ok1 | acc1;
    assign ready2   = ~st2.need_mem | addr_ok2 | acc2;
    assign ready_go = (ready1 & ready2) | clear_all;

    assign allowin  = ~valid_q | (ready_go & ms_allowin);
    assign ms_valid = valid_q & ready_go & ~flush1;

    assign req_en1 = valid_q & ms_allowin & ~acc1;
    assign req_en2 = valid_q & ms_allowin & ~acc2 & ~flush1;  // lane 1 flush kills lane 2

    assign lane2_live = bus_q.lane2.valid & ~flush1 & ~st2.except;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (clear_all) begin
            valid_q <= 1'b0;
        end else if (allowin) begin
            valid_q <= es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es_valid && allowin) begin
            bus_r <= es_bus;
        end
    end

    // accepted latches drop when the bundle leaves or is flushed
    always_ff @(posedge clk) begin
        if (reset) begin
            acc1 <= 1'b0;
            acc2 <= 1'b0;
        end else if ((ms_valid && ms_allowin) || clear_all) begin
            acc1 <= 1'b0;
            acc2 <= 1'b0;
        end else begin
            if (addr_ok1) begin
                acc1 <= 1'b1;
            end
            if (addr_ok2) begin
                acc2 <= 1'b1;
            end
        end
    end

    // lane status comes back through mem_lane gated by the lane valid
    a_clear_needs_valid: assert property (
        @(posedge clk) disable iff (reset) clear_all |-> valid_q
    );

    // flush empties the stage so lane 2 stays quiet on the next cycle too
    a_no_req2_on_flush: assert property (
        @(posedge clk) disable iff (reset) flush1 |-> !req_en2 ##1 !req_en2
    );

endmodule

// File: logic/pms_pkg.sv
package pms_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] REFILL_VEC = 32'hbfc0_0200;
    localparam logic [XLEN-1:0] EXC_VEC    = 32'hbfc0_0380;

    localparam logic [4:0] EXC_ADEL = 5'd4;  // misaligned load
    localparam logic [4:0] EXC_ADES = 5'd5;  // misaligned store

    // one-hot access kind with b as the msb
    typedef struct packed {
        logic b;
        logic bu;
        logic h;
        logic hu;
        logic w;
        logic wl;
        logic wr;
    } ls_type_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] mem_addr;
        logic [XLEN-1:0] rt_value;
        logic [XLEN-1:0] result;
        ls_type_t        ls_type;
        logic            load_op;
        logic            mem_we;
        logic            gr_we;
        logic [4:0]      dest;
        logic            es_except;
        logic [4:0]      es_exccode;
        logic [XLEN-1:0] es_badvaddr;
        logic            eret;
        logic            refill;
        logic            bd;
    } lane_in_t;

    typedef struct packed {
        lane_in_t        lane1;
        lane_in_t        lane2;
        logic [XLEN-1:0] br_target;
    } es_bus_t;

    typedef struct packed {
        logic [19:0] tag;
        logic [7:0]  index;
        logic [3:0]  offset;
    } cache_split_t;

    // same physical address as raw word or as cache fields
    typedef union packed {
        logic [XLEN-1:0] raw;
        cache_split_t    split;
    } cache_addr_u;

    typedef struct packed {
        logic            valid;
        logic            op;
        logic            uncache;
        logic [19:0]     tag;
        logic [7:0]      index;
        logic [3:0]      offset;
        logic [1:0]      size;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic            need_mem;
        logic            except;
        logic [4:0]      exccode;
        logic [XLEN-1:0] badvaddr;
        logic            eret;
        logic            refill;
        logic            bd;
        logic [XLEN-1:0] pc;
    } lane_status_t;

    typedef struct packed {
        logic            valid;
        ls_type_t        ls_type;
        logic [1:0]      offset;
        logic            load_op;
        logic            mem_we;
        logic            gr_we;
        logic [4:0]      dest;
        logic [XLEN-1:0] rt_value;
        logic [XLEN-1:0] result;
        logic [XLEN-1:0] pc;
    } ms_lane_t;

    typedef struct packed {
        logic            ex;
        logic [4:0]      ex_type;
        logic            bd;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] badvaddr;
        logic            eret;
    } except_rpt_t;

endpackage
